/* hdl/audio_channel_mixer.sv */
// One audio channel: sum with host PCM, crossmix, attenuate and clamp
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_macros.svh"

module audio_channel_mixer (
	input  wire                          clk,
	input  wire                          resetd,
	input  audio_mix_pkg::audio_sample_t i_core,
	input  wire                          i_core_signed,
	input  audio_mix_pkg::audio_sample_t i_linux,
	input  audio_mix_pkg::audio_sample_t i_pre_other,
	input  audio_mix_pkg::mix_mode_t     i_mix,
	input  audio_mix_pkg::att_t          i_att,
	output audio_mix_pkg::audio_sample_t o_pre,
	output audio_mix_pkg::audio_sample_t o_audio
);

	import audio_mix_pkg::*;

	mix_acc_t      a1;
	mix_acc_t      a2;
	mix_acc_t      a3;
	mix_acc_t      a4;
	mix_acc_t      linux_ext;
	mix_acc_t      other_ext;
	audio_sample_t pre;
	audio_sample_t out;

	assign linux_ext = {i_linux[`AUDIO_W-1], i_linux};
	assign other_ext = {i_pre_other[`AUDIO_W-1], i_pre_other};

	////////////////////////////////////////////////////////////////////////////
	// Conversion and sum
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1  <= '0;
			a2  <= '0;
			pre <= '0;
		end else begin
			// Unsigned core audio is halved around zero
			if (i_core_signed) begin
				a1 <= {i_core[`AUDIO_W-1], i_core};
			end else begin
				a1 <= {2'b00, i_core[`AUDIO_W-1:1]};
			end
			a2  <= a1 + linux_ext;
			// Pre-mix for the opposite channel
			pre <= a2[`ACC_W-1:1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Crossmix, attenuation and clamp
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a3  <= '0;
			a4  <= '0;
			out <= '0;
		end else begin
			case (i_mix)
				MIX_OFF:     a3 <= a2;
				MIX_EIGHTH:  a3 <= a2 - (a2 >>> 3) + (other_ext >>> 2);
				MIX_QUARTER: a3 <= a2 - (a2 >>> 2) + (other_ext >>> 1);
				MIX_MONO:    a3 <= (a2 >>> 1) + other_ext;
			endcase

			if (i_att[`ATT_W-1]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[`ATT_W-2:0];
			end

			// Guard bit and sign disagree on overflow
			if (a4[`ACC_W-1] ^ a4[`ACC_W-2]) begin
				out <= {a4[`ACC_W-1], {(`AUDIO_W-1){~a4[`ACC_W-1]}}};
			end else begin
				out <= a4[`AUDIO_W-1:0];
			end
		end
	end

	assign o_pre   = pre;
	assign o_audio = out;

endmodule

`default_nettype wire

/* hdl/audio_mix_macros.svh */
// Audio mix widths and host command codes shared by the mixing path
`ifndef AUDIO_MIX_MACROS_SVH
`define AUDIO_MIX_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////

// PCM sample as seen on every audio port
`define AUDIO_W 16

// One guard bit above the sample for the sum
`define ACC_W 17

// Mute bit plus four shift bits
`define ATT_W 5

////////////////////////////////////////////////////////////////////////////
// Host command channel
////////////////////////////////////////////////////////////////////////////

`define IO_W 16
`define CMD_W 8

// Volume attenuation command
`define CMD_VOL_ATT 8'h26

`endif

/* hdl/audio_mix_pkg.sv */
// Types for the audio mixing path and its host command decoder
`default_nettype none

package audio_mix_pkg;

	`include "audio_mix_macros.svh"

	// Raw PCM sample, signedness decided by the consumer
	typedef logic [`AUDIO_W-1:0] audio_sample_t;

	// Mixer working value
	typedef logic signed [`ACC_W-1:0] mix_acc_t;

	// Bit 4 mutes, bits 3..0 are the right shift
	typedef logic [`ATT_W-1:0] att_t;

	typedef logic [`IO_W-1:0] io_word_t;

	// Crossmix between the two channels
	typedef enum logic [1:0] {
		MIX_OFF     = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_MONO    = 2'd3
	} mix_mode_t;

	// Command decoder FSM
	typedef enum logic {
		WAIT_CMD  = 1'b0,
		TAKE_DATA = 1'b1
	} dec_state_t;

endpackage

`default_nettype wire

/* hdl/audio_mix_top.sv */
// Stereo audio mixer with host volume control and core sample filtering
`timescale 1ns/1ps
`default_nettype none

module audio_mix_top (
	input  wire                          clk,
	input  wire                          resetd,
	input  wire                          i_io_uio,
	input  wire                          i_io_strobe,
	input  audio_mix_pkg::io_word_t      i_io_din,
	input  audio_mix_pkg::audio_sample_t i_core_l,
	input  audio_mix_pkg::audio_sample_t i_core_r,
	input  wire                          i_core_signed,
	input  audio_mix_pkg::mix_mode_t     i_audio_mix,
	input  audio_mix_pkg::audio_sample_t i_linux_l,
	input  audio_mix_pkg::audio_sample_t i_linux_r,
	output audio_mix_pkg::audio_sample_t o_audio_l,
	output audio_mix_pkg::audio_sample_t o_audio_r
);

	import audio_mix_pkg::*;

	att_t          att;
	audio_sample_t held_l;
	audio_sample_t held_r;
	audio_sample_t pre_l;
	audio_sample_t pre_r;

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	io_cmd_decoder u_cmd (
		.clk        (clk),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_att      (att)
	);

	////////////////////////////////////////////////////////////////////////////
	// Core sample filters
	////////////////////////////////////////////////////////////////////////////

	audio_sample_filter u_filt_l (
		.clk     (clk),
		.resetd  (resetd),
		.i_sample(i_core_l),
		.o_sample(held_l)
	);

	audio_sample_filter u_filt_r (
		.clk     (clk),
		.resetd  (resetd),
		.i_sample(i_core_r),
		.o_sample(held_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Mixers, pre-mix crossed between channels
	////////////////////////////////////////////////////////////////////////////

	audio_channel_mixer u_mix_l (
		.clk          (clk),
		.resetd       (resetd),
		.i_core       (held_l),
		.i_core_signed(i_core_signed),
		.i_linux      (i_linux_l),
		.i_pre_other  (pre_r),
		.i_mix        (i_audio_mix),
		.i_att        (att),
		.o_pre        (pre_l),
		.o_audio      (o_audio_l)
	);

	audio_channel_mixer u_mix_r (
		.clk          (clk),
		.resetd       (resetd),
		.i_core       (held_r),
		.i_core_signed(i_core_signed),
		.i_linux      (i_linux_r),
		.i_pre_other  (pre_l),
		.i_mix        (i_audio_mix),
		.i_att        (att),
		.o_pre        (pre_r),
		.o_audio      (o_audio_r)
	);

endmodule

`default_nettype wire

/* hdl/audio_sample_filter.sv */
// Core audio sample filter that passes a value only once it has held steady
`timescale 1ns/1ps
`default_nettype none

module audio_sample_filter (
	input  wire                        clk,
	input  wire                        resetd,
	input  audio_mix_pkg::audio_sample_t i_sample,
	output audio_mix_pkg::audio_sample_t o_sample
);

	import audio_mix_pkg::*;

	// Sample history, d1 is the newest
	audio_sample_t d1;
	audio_sample_t d2;
	audio_sample_t d3;

	audio_sample_t held;

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1   <= '0;
			d2   <= '0;
			d3   <= '0;
			held <= '0;
		end else begin
			d1 <= i_sample;
			d2 <= d1;
			d3 <= d2;
			// Two matching stages, so a one-cycle glitch is dropped
			if (d2 == d3) begin
				held <= d2;
			end
		end
	end

	assign o_sample = held;

endmodule

`default_nettype wire

/* hdl/io_cmd_decoder.sv */
// Host bus command decoder holding the volume attenuation setting
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_macros.svh"

module io_cmd_decoder (
	input  wire                   clk,
	input  wire                   resetd,
	input  wire                   i_io_uio,
	input  wire                   i_io_strobe,
	input  audio_mix_pkg::io_word_t i_io_din,
	output audio_mix_pkg::att_t   o_att
);

	import audio_mix_pkg::*;

	dec_state_t          state;
	logic [`CMD_W-1:0]   cmd;
	logic                old_strobe;
	logic                word_rise;
	att_t                att;

	// One word per rising edge of the strobe level
	assign word_rise = i_io_strobe & ~old_strobe;

	always_ff @(posedge clk) begin
		if (resetd) begin
			old_strobe <= 1'b0;
		end else begin
			old_strobe <= i_io_strobe;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state <= WAIT_CMD;
			cmd   <= '0;
			att   <= '0;
		end else if (!i_io_uio) begin
			// Deselect ends the transfer
			state <= WAIT_CMD;
			cmd   <= '0;
		end else if (word_rise) begin
			case (state)
				WAIT_CMD: begin
					cmd   <= i_io_din[`CMD_W-1:0];
					state <= TAKE_DATA;
				end
				TAKE_DATA: begin
					// Only the volume command is decoded
					if (cmd == `CMD_VOL_ATT) begin
						att <= i_io_din[`ATT_W-1:0];
					end
				end
			endcase
		end
	end

	assign o_att = att;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the audio mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tb_audio_mix -Mdir "$OBJ" -o sim_tb_audio_mix
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb_audio_mix" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Simulation finished without failure"
exit 0

/* tb.f */
+incdir+hdl
hdl/audio_mix_pkg.sv
hdl/io_cmd_decoder.sv
hdl/audio_sample_filter.sv
hdl/audio_channel_mixer.sv
hdl/audio_mix_top.sv
verification/audio_mix_asserts.sv
verification/tb_audio_mix.sv

/* verification/audio_mix_asserts.sv */
// Bound checks on the mixer reset state, volume register updates and mute
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_macros.svh"

module audio_mix_asserts (
	input  wire                          clk,
	input  wire                          resetd,
	input  wire                          i_io_uio,
	input  wire                          i_io_strobe,
	input  audio_mix_pkg::att_t          i_att,
	input  audio_mix_pkg::audio_sample_t i_audio_l,
	input  audio_mix_pkg::audio_sample_t i_audio_r
);

	logic strobe_q;
	logic word_rise;

	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= i_io_strobe;
		end
	end

	assign word_rise = i_io_strobe & ~strobe_q;

	// Whole pipeline cleared by reset
	reset_clears_outputs: assert property (@(posedge clk)
		resetd |=> (i_audio_l == '0 && i_audio_r == '0))
		else $error("outputs not zero in the cycle after reset");

	// Volume register loads only on a selected bus word
	att_follows_word: assert property (@(posedge clk) disable iff (resetd)
		$changed(i_att) |-> $past(word_rise && i_io_uio))
		else $error("attenuation changed without a selected strobe edge");

	// Mute zeroes stage 4, output register follows one cycle later
	mute_zeroes_outputs: assert property (@(posedge clk) disable iff (resetd)
		i_att[`ATT_W-1] |=> ##1 (i_audio_l == '0 && i_audio_r == '0))
		else $error("outputs not zero while muted");

endmodule

`default_nettype wire

/* verification/audio_mix_golden.txt */
# send att mode signed core_l core_r glitch glitch_val linux_l linux_r exp_l exp_r, all hex
# send: 0 none, 1 volume command, 2 volume words with select low, 3 other command
1 00 0 1 1000 f000 0 0000 0200 0100 1200 f100
1 02 0 1 1000 f000 0 0000 0200 0100 0480 fc40
1 05 0 1 1234 edcb 0 0000 0011 fff0 0092 ff6d
2 00 0 1 1234 edcb 0 0000 0011 fff0 0092 ff6d
3 00 0 1 2000 e000 0 0000 0000 0000 0100 ff00
1 10 0 1 1000 f000 0 0000 0200 0100 0000 0000
1 1f 3 1 7fff 8000 0 0000 7fff 8000 0000 0000
1 00 0 1 0300 0400 1 7fff 0000 0000 0300 0400
0 00 0 1 0300 0400 1 8001 0000 0000 0300 0400
0 00 1 1 1000 0800 0 0000 0000 0000 0f00 0900
0 00 2 1 1000 0800 0 0000 0000 0000 0e00 0a00
0 00 3 1 1000 0800 0 0000 0000 0000 0c00 0c00
0 00 2 1 f000 0000 0 0000 0000 ff00 f3c0 fb40
0 00 0 0 8000 ffff 0 0000 0010 ffff 4010 7ffe
0 00 3 0 4000 2000 0 0000 0000 0000 1800 1800
0 00 1 0 c000 0100 0 0000 fff8 0001 5409 0c70
0 00 0 1 7000 9000 0 0000 7000 9000 7fff 8000
0 00 3 1 8000 8000 0 0000 8000 8000 8000 8000
0 00 3 1 7fff 7fff 0 0000 7fff 7fff 7fff 7fff

/* verification/tb_audio_mix.sv */
// Testbench for the stereo audio mixer, driven by golden stimulus and expected outputs
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_macros.svh"

module tb_audio_mix;

	import audio_mix_pkg::*;

	localparam int          SETTLE_CYCLES  = 16;
	localparam int          TIMEOUT_CYCLES = 1000;
	localparam int          RESET_CYCLES   = 10;
	localparam logic [31:0] SEED           = 32'h144c6a99;
	localparam logic [7:0]  OTHER_CMD      = 8'h27;
	localparam string       GOLDEN_FILE    = "verification/audio_mix_golden.txt";

	logic          clk;
	logic          resetd;
	logic          i_io_uio;
	logic          i_io_strobe;
	io_word_t      i_io_din;
	audio_sample_t i_core_l;
	audio_sample_t i_core_r;
	logic          i_core_signed;
	mix_mode_t     i_audio_mix;
	audio_sample_t i_linux_l;
	audio_sample_t i_linux_r;
	audio_sample_t o_audio_l;
	audio_sample_t o_audio_r;

	// One golden case, all fields hex
	logic [15:0] vec_send;
	logic [15:0] vec_att;
	logic [15:0] vec_mode;
	logic [15:0] vec_signed;
	logic [15:0] vec_core_l;
	logic [15:0] vec_core_r;
	logic [15:0] vec_glitch;
	logic [15:0] vec_glitch_val;
	logic [15:0] vec_linux_l;
	logic [15:0] vec_linux_r;
	logic [15:0] vec_exp_l;
	logic [15:0] vec_exp_r;

	int          fd;
	int          nread;
	int          nfields;
	int          cases;
	string       line;

	audio_mix_top dut (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_core_l     (i_core_l),
		.i_core_r     (i_core_r),
		.i_core_signed(i_core_signed),
		.i_audio_mix  (i_audio_mix),
		.i_linux_l    (i_linux_l),
		.i_linux_r    (i_linux_r),
		.o_audio_l    (o_audio_l),
		.o_audio_r    (o_audio_r)
	);

	bind audio_mix_top audio_mix_asserts u_asserts (
		.clk        (clk),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_strobe(i_io_strobe),
		.i_att      (att),
		.i_audio_l  (o_audio_l),
		.i_audio_r  (o_audio_r)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [`AUDIO_W-1:0] got,
		input logic [`AUDIO_W-1:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, expected);
			$display("test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// Advance to a later falling edge
	task automatic step_cycles(input int count);
		int waited;
		waited = 0;
		while (waited < count) begin
			if (waited >= TIMEOUT_CYCLES) begin
				fail_run("timeout while waiting for clock cycles");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	function automatic io_word_t filler_word();
		return io_word_t'($urandom);
	endfunction

	// Command word then data word, one strobe rise each
	task automatic send_words(input logic sel, input io_word_t cmd_word,
		input io_word_t data_word);
		i_io_uio = sel;
		i_io_din = filler_word();
		step_cycles(1);
		i_io_din    = cmd_word;
		i_io_strobe = 1'b1;
		step_cycles(1);
		i_io_strobe = 1'b0;
		i_io_din    = filler_word();
		step_cycles(1);
		i_io_din    = data_word;
		i_io_strobe = 1'b1;
		step_cycles(1);
		i_io_strobe = 1'b0;
		i_io_din    = filler_word();
		step_cycles(1);
		i_io_uio = 1'b0;
		step_cycles(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One golden case
	////////////////////////////////////////////////////////////////////////////

	task automatic run_case();
		io_word_t att_word;
		int       cycle;
		att_word = {{(`IO_W-`ATT_W){1'b0}}, vec_att[`ATT_W-1:0]};
		// 1 selected volume write, 2 same words deselected, 3 other command
		if (vec_send == 16'd1) begin
			send_words(1'b1, io_word_t'(`CMD_VOL_ATT), att_word);
		end else if (vec_send == 16'd2) begin
			send_words(1'b0, io_word_t'(`CMD_VOL_ATT), att_word);
		end else if (vec_send == 16'd3) begin
			send_words(1'b1, io_word_t'(OTHER_CMD), att_word);
		end
		i_core_signed = vec_signed[0];
		i_audio_mix   = mix_mode_t'(vec_mode[1:0]);
		i_core_l      = vec_core_l;
		i_core_r      = vec_core_r;
		i_linux_l     = vec_linux_l;
		i_linux_r     = vec_linux_r;
		step_cycles(SETTLE_CYCLES);
		check_value("o_audio_l", o_audio_l, vec_exp_l);
		check_value("o_audio_r", o_audio_r, vec_exp_r);
		// Settled outputs must hold every cycle after a one-cycle glitch
		if (vec_glitch != 16'd0) begin
			i_core_l = vec_glitch_val;
			i_core_r = vec_glitch_val;
			step_cycles(1);
			i_core_l = vec_core_l;
			i_core_r = vec_core_r;
			for (cycle = 0; cycle < SETTLE_CYCLES; cycle++) begin
				step_cycles(1);
				check_value("o_audio_l", o_audio_l, vec_exp_l);
				check_value("o_audio_r", o_audio_r, vec_exp_r);
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clk           = 1'b0;
		resetd        = 1'b1;
		i_io_uio      = 1'b0;
		i_io_strobe   = 1'b0;
		i_io_din      = '0;
		i_core_l      = '0;
		i_core_r      = '0;
		i_core_signed = 1'b1;
		i_audio_mix   = MIX_OFF;
		i_linux_l     = '0;
		i_linux_r     = '0;

		step_cycles(RESET_CYCLES);
		resetd = 1'b0;
		check_value("o_audio_l", o_audio_l, '0);
		check_value("o_audio_r", o_audio_r, '0);

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			fail_run("cannot open the golden vector file");
		end
		cases = 0;
		while (!$feof(fd)) begin
			line  = "";
			nread = $fgets(line, fd);
			// Skip comment and empty lines
			if (nread > 0 && line.len() > 1 && line.getc(0) != "#") begin
				nfields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
					vec_send, vec_att, vec_mode, vec_signed, vec_core_l, vec_core_r,
					vec_glitch, vec_glitch_val, vec_linux_l, vec_linux_r,
					vec_exp_l, vec_exp_r);
				if (nfields != 12) begin
					fail_run("golden vector line has the wrong number of fields");
				end
				run_case();
				cases++;
			end
		end
		$fclose(fd);

		if (cases == 0) begin
			fail_run("golden vector file holds no cases");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
